// ==== common/rv_pkg.sv ====
/*
	RV32I core package
	Widths, opcode and funct3 codes, the decoded control word,
	the memory request formats and the port handshake states
*/

package rv_pkg;

	localparam int XLEN = 32;
	localparam logic [XLEN-1:0] PC_RESET = 32'h0000_0000;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [XLEN-1:0] addr_t;
	typedef logic [4:0]      reg_idx_t;
	typedef logic [3:0]      strb_t;

	// Major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

	// Branch conditions
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// Access sizes, shared by loads and stores
	localparam logic [2:0] F3_B  = 3'b000;
	localparam logic [2:0] F3_H  = 3'b001;
	localparam logic [2:0] F3_W  = 3'b010;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;

	// Write-back source
	localparam logic [1:0] WB_ALU = 2'd0;
	localparam logic [1:0] WB_MEM = 2'd1;
	localparam logic [1:0] WB_PC4 = 2'd2;

	// Jump kind
	localparam logic [1:0] JUMP_NONE = 2'd0;
	localparam logic [1:0] JUMP_JAL  = 2'd1;
	localparam logic [1:0] JUMP_JALR = 2'd2;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
	} alu_op_e;

	typedef struct packed {
		alu_op_e    alu_op;
		logic       src_a_pc;
		logic       src_b_imm;
		logic       reg_write;
		logic       mem_read;
		logic       mem_write;
		logic [1:0] wb_sel;
		logic       branch;
		logic [1:0] jump;
	} ctrl_t;

	typedef struct packed {
		addr_t addr;
	} im_req_t;

	typedef struct packed {
		addr_t addr;
		word_t wdata;
		strb_t strb;
		logic  write;
	} dm_req_t;

	typedef enum logic [1:0] {
		IDLE,
		WAIT,
		DONE
	} port_state_e;

endpackage

// ==== core/rv_main_control.sv ====
/*
	Main decoder
	Turns opcode, funct3 and funct7 into the control word
*/

`timescale 1ns/1ps

module rv_main_control (
	input  rv_pkg::word_t i_instr,
	output rv_pkg::ctrl_t o_ctrl
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       alt;

	assign opcode = i_instr[6:0];
	assign funct3 = i_instr[14:12];
	// funct7 bit 5 picks SUB and SRA
	assign alt = i_instr[30];

	function automatic rv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic sub_ok,
		input logic alt_bit);
		case (f3)
			3'b000:  arith_op = (sub_ok && alt_bit) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
			3'b001:  arith_op = rv_pkg::ALU_SLL;
			3'b010:  arith_op = rv_pkg::ALU_SLT;
			3'b011:  arith_op = rv_pkg::ALU_SLTU;
			3'b100:  arith_op = rv_pkg::ALU_XOR;
			3'b101:  arith_op = alt_bit ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
			3'b110:  arith_op = rv_pkg::ALU_OR;
			default: arith_op = rv_pkg::ALU_AND;
		endcase
	endfunction

	always_comb begin
		// All inactive unless an opcode matches
		o_ctrl        = '0;
		o_ctrl.alu_op = rv_pkg::ALU_ADD;
		o_ctrl.wb_sel = rv_pkg::WB_ALU;
		o_ctrl.jump   = rv_pkg::JUMP_NONE;
		case (opcode)
			rv_pkg::OPC_OP: begin
				o_ctrl.alu_op    = arith_op(funct3, 1'b1, alt);
				o_ctrl.reg_write = 1'b1;
			end
			rv_pkg::OPC_OP_IMM: begin
				o_ctrl.alu_op    = arith_op(funct3, 1'b0, alt);
				o_ctrl.src_b_imm = 1'b1;
				o_ctrl.reg_write = 1'b1;
			end
			rv_pkg::OPC_LUI: begin
				o_ctrl.alu_op    = rv_pkg::ALU_PASS_B;
				o_ctrl.src_b_imm = 1'b1;
				o_ctrl.reg_write = 1'b1;
			end
			rv_pkg::OPC_AUIPC: begin
				o_ctrl.src_a_pc  = 1'b1;
				o_ctrl.src_b_imm = 1'b1;
				o_ctrl.reg_write = 1'b1;
			end
			rv_pkg::OPC_LOAD: begin
				o_ctrl.src_b_imm = 1'b1;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.mem_read  = 1'b1;
				o_ctrl.wb_sel    = rv_pkg::WB_MEM;
			end
			rv_pkg::OPC_STORE: begin
				o_ctrl.src_b_imm = 1'b1;
				o_ctrl.mem_write = 1'b1;
			end
			rv_pkg::OPC_BRANCH: begin
				o_ctrl.alu_op = rv_pkg::ALU_SUB;
				o_ctrl.branch = 1'b1;
			end
			rv_pkg::OPC_JAL: begin
				o_ctrl.reg_write = 1'b1;
				o_ctrl.wb_sel    = rv_pkg::WB_PC4;
				o_ctrl.jump      = rv_pkg::JUMP_JAL;
			end
			rv_pkg::OPC_JALR: begin
				o_ctrl.src_b_imm = 1'b1;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.wb_sel    = rv_pkg::WB_PC4;
				o_ctrl.jump      = rv_pkg::JUMP_JALR;
			end
			default: ;
		endcase
	end

endmodule

// ==== core/rv_imm_gen.sv ====
/*
	Immediate generator
	Sign-extended I, S, B, U and J immediates, format taken from the opcode
*/

`timescale 1ns/1ps

module rv_imm_gen (
	input  rv_pkg::word_t i_instr,
	output rv_pkg::word_t o_imm
);

	logic [6:0] opcode;
	logic       sign;

	assign opcode = i_instr[6:0];
	assign sign   = i_instr[31];

	always_comb begin
		case (opcode)
			rv_pkg::OPC_OP_IMM, rv_pkg::OPC_LOAD, rv_pkg::OPC_JALR:
				o_imm = {{20{sign}}, i_instr[31:20]};
			rv_pkg::OPC_STORE:
				o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
			rv_pkg::OPC_BRANCH:
				o_imm = {{19{sign}}, sign, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
			rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC:
				o_imm = {i_instr[31:12], 12'b0};
			rv_pkg::OPC_JAL:
				o_imm = {{11{sign}}, sign, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
			// R-type has no immediate
			default:
				o_imm = '0;
		endcase
	end

endmodule

// ==== core/rv_alu.sv ====
/*
	ALU
	Arithmetic, logic and shift operations plus the branch compare
*/

`timescale 1ns/1ps

module rv_alu (
	input  rv_pkg::word_t   i_a,
	input  rv_pkg::word_t   i_b,
	input  rv_pkg::alu_op_e i_op,
	input  logic [2:0]      i_funct3,
	output rv_pkg::word_t   o_res,
	output logic            o_branch_taken
);

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;
	logic       eq;

	assign shamt = i_b[4:0];
	assign lt_s  = $signed(i_a) < $signed(i_b);
	assign lt_u  = i_a < i_b;
	assign eq    = i_a == i_b;

	always_comb begin
		case (i_op)
			rv_pkg::ALU_ADD:    o_res = i_a + i_b;
			rv_pkg::ALU_SUB:    o_res = i_a - i_b;
			rv_pkg::ALU_SLL:    o_res = i_a << shamt;
			rv_pkg::ALU_SLT:    o_res = {31'b0, lt_s};
			rv_pkg::ALU_SLTU:   o_res = {31'b0, lt_u};
			rv_pkg::ALU_XOR:    o_res = i_a ^ i_b;
			rv_pkg::ALU_SRL:    o_res = i_a >> shamt;
			rv_pkg::ALU_SRA:    o_res = $signed(i_a) >>> shamt;
			rv_pkg::ALU_OR:     o_res = i_a | i_b;
			rv_pkg::ALU_AND:    o_res = i_a & i_b;
			default:            o_res = i_b;
		endcase
	end

	// Condition only, the decoder says whether it is a branch
	always_comb begin
		case (i_funct3)
			rv_pkg::F3_BEQ:  o_branch_taken = eq;
			rv_pkg::F3_BNE:  o_branch_taken = !eq;
			rv_pkg::F3_BLT:  o_branch_taken = lt_s;
			rv_pkg::F3_BGE:  o_branch_taken = !lt_s;
			rv_pkg::F3_BLTU: o_branch_taken = lt_u;
			rv_pkg::F3_BGEU: o_branch_taken = !lt_u;
			default:         o_branch_taken = 1'b0;
		endcase
	end

endmodule

// ==== core/rv_reg_file.sv ====
/*
	Register file
	32 x 32, two asynchronous reads, one synchronous write, x0 reads zero
*/

`timescale 1ns/1ps

module rv_reg_file (
	input  logic             i_clk,
	input  rv_pkg::reg_idx_t i_rs1,
	input  rv_pkg::reg_idx_t i_rs2,
	output rv_pkg::word_t    o_rd1,
	output rv_pkg::word_t    o_rd2,
	input  logic             i_we,
	input  rv_pkg::reg_idx_t i_rd,
	input  rv_pkg::word_t    i_wd
);

	rv_pkg::word_t regs [32];

	always_ff @(posedge i_clk) begin
		if (i_we && (i_rd != '0)) begin
			regs[i_rd] <= i_wd;
		end
	end

	// x0 is never written, force zero on read
	assign o_rd1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
	assign o_rd2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// ==== core/rv_data_port.sv ====
/*
	Data memory port
	Lane alignment and byte strobes for stores, shift and extension for loads,
	and the req/ready handshake with its stall
*/

`timescale 1ns/1ps

module rv_data_port (
	input  logic              i_clk,
	input  logic              i_rst,
	input  rv_pkg::addr_t     i_addr,
	input  rv_pkg::word_t     i_wdata,
	input  logic [2:0]        i_funct3,
	input  logic              i_read,
	input  logic              i_write,
	output rv_pkg::word_t     o_rdata,
	output logic              o_stall,
	output logic              o_dm_valid,
	output rv_pkg::dm_req_t   o_dm_req,
	input  logic              i_dm_ready,
	input  rv_pkg::word_t     i_dm_rdata
);

	rv_pkg::port_state_e state;
	rv_pkg::word_t       rdata_q;
	rv_pkg::word_t       shifted;
	logic [4:0]          lane_shift;
	logic                access;

	assign access     = i_read || i_write;
	assign lane_shift = {i_addr[1:0], 3'b000};

	always_ff @(posedge i_clk) begin
		if (!i_rst) begin
			state <= rv_pkg::IDLE;
		end else begin
			case (state)
				rv_pkg::IDLE: if (access) state <= rv_pkg::WAIT;
				rv_pkg::WAIT: if (i_dm_ready) state <= rv_pkg::DONE;
				default:      state <= rv_pkg::IDLE;
			endcase
		end
	end

	// Raw word taken at the handshake
	always_ff @(posedge i_clk) begin
		if ((state == rv_pkg::WAIT) && i_dm_ready) begin
			rdata_q <= i_dm_rdata;
		end
	end

	// Instruction completes in DONE
	assign o_stall    = access && (state != rv_pkg::DONE);
	assign o_dm_valid = state == rv_pkg::WAIT;

	assign o_dm_req.addr  = {i_addr[31:2], 2'b00};
	assign o_dm_req.wdata = i_wdata << lane_shift;
	assign o_dm_req.write = i_write;

	always_comb begin
		case (i_funct3)
			rv_pkg::F3_B: o_dm_req.strb = 4'b0001 << i_addr[1:0];
			rv_pkg::F3_H: o_dm_req.strb = 4'b0011 << i_addr[1:0];
			default:      o_dm_req.strb = 4'b1111;
		endcase
	end

	assign shifted = rdata_q >> lane_shift;

	always_comb begin
		case (i_funct3)
			rv_pkg::F3_B:  o_rdata = {{24{shifted[7]}}, shifted[7:0]};
			rv_pkg::F3_H:  o_rdata = {{16{shifted[15]}}, shifted[15:0]};
			rv_pkg::F3_BU: o_rdata = {24'b0, shifted[7:0]};
			rv_pkg::F3_HU: o_rdata = {16'b0, shifted[15:0]};
			default:       o_rdata = shifted;
		endcase
	end

endmodule

// ==== core/rv_datapath.sv ====
/*
	Single-cycle datapath
	PC and next-PC selection, operand and write-back muxes, stall
	combination, and the decode, register, ALU and data port blocks
*/

`timescale 1ns/1ps

module rv_datapath (
	input  logic            i_clk,
	input  logic            i_rst,
	output rv_pkg::addr_t   o_pc,
	input  rv_pkg::word_t   i_instr,
	input  logic            i_fetch_stall,
	output logic            o_dm_valid,
	output rv_pkg::dm_req_t o_dm_req,
	input  logic            i_dm_ready,
	input  rv_pkg::word_t   i_dm_rdata
);

	rv_pkg::addr_t pc;
	rv_pkg::addr_t pc_next;
	rv_pkg::addr_t pc_plus4;
	rv_pkg::addr_t pc_target;
	rv_pkg::ctrl_t ctrl;
	rv_pkg::word_t rd1;
	rv_pkg::word_t rd2;
	rv_pkg::word_t imm;
	rv_pkg::word_t op_a;
	rv_pkg::word_t op_b;
	rv_pkg::word_t alu_res;
	rv_pkg::word_t load_data;
	rv_pkg::word_t wb_data;
	logic [2:0]    funct3;
	logic          cond_true;
	logic          take_branch;
	logic          mem_stall;
	logic          stall;

	assign funct3 = i_instr[14:12];

	// One stall gates both PC and register write
	assign stall = i_fetch_stall || mem_stall;

	always_ff @(posedge i_clk) begin
		if (!i_rst) begin
			pc <= rv_pkg::PC_RESET;
		end else if (!stall) begin
			pc <= pc_next;
		end
	end

	assign o_pc        = pc;
	assign pc_plus4    = pc + 32'd4;
	assign pc_target   = pc + imm;
	assign take_branch = ctrl.branch && cond_true;

	always_comb begin
		case (ctrl.jump)
			rv_pkg::JUMP_JALR: pc_next = {alu_res[31:1], 1'b0};
			rv_pkg::JUMP_JAL:  pc_next = pc_target;
			default:           pc_next = take_branch ? pc_target : pc_plus4;
		endcase
	end

	rv_main_control u_main_control (
		.i_instr (i_instr),
		.o_ctrl  (ctrl)
	);

	rv_reg_file u_reg_file (
		.i_clk (i_clk),
		.i_rs1 (i_instr[19:15]),
		.i_rs2 (i_instr[24:20]),
		.o_rd1 (rd1),
		.o_rd2 (rd2),
		.i_we  (ctrl.reg_write && !stall),
		.i_rd  (i_instr[11:7]),
		.i_wd  (wb_data)
	);

	rv_imm_gen u_imm_gen (
		.i_instr (i_instr),
		.o_imm   (imm)
	);

	assign op_a = ctrl.src_a_pc ? pc : rd1;
	assign op_b = ctrl.src_b_imm ? imm : rd2;

	rv_alu u_alu (
		.i_a            (op_a),
		.i_b            (op_b),
		.i_op           (ctrl.alu_op),
		.i_funct3       (funct3),
		.o_res          (alu_res),
		.o_branch_taken (cond_true)
	);

	// Latched word is stale until the fetch completes
	rv_data_port u_data_port (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_addr     (alu_res),
		.i_wdata    (rd2),
		.i_funct3   (funct3),
		.i_read     (ctrl.mem_read && !i_fetch_stall),
		.i_write    (ctrl.mem_write && !i_fetch_stall),
		.o_rdata    (load_data),
		.o_stall    (mem_stall),
		.o_dm_valid (o_dm_valid),
		.o_dm_req   (o_dm_req),
		.i_dm_ready (i_dm_ready),
		.i_dm_rdata (i_dm_rdata)
	);

	always_comb begin
		case (ctrl.wb_sel)
			rv_pkg::WB_MEM: wb_data = load_data;
			rv_pkg::WB_PC4: wb_data = pc_plus4;
			default:        wb_data = alu_res;
		endcase
	end

endmodule

// ==== verilog/rv_fetch.sv ====
/*
	Fetch unit
	One-entry instruction latch, requests the PC on a miss and stalls
	until the instruction memory answers
*/

`timescale 1ns/1ps

module rv_fetch (
	input  logic            i_clk,
	input  logic            i_rst,
	input  rv_pkg::addr_t   i_pc,
	output rv_pkg::word_t   o_instr,
	output logic            o_stall,
	output logic            o_im_valid,
	output rv_pkg::im_req_t o_im_req,
	input  logic            i_im_ready,
	input  rv_pkg::word_t   i_im_data
);

	rv_pkg::port_state_e state;
	rv_pkg::addr_t       tag;
	rv_pkg::word_t       instr_q;
	logic                valid;
	logic                hit;

	assign hit = valid && (tag == i_pc);

	always_ff @(posedge i_clk) begin
		if (!i_rst) begin
			state <= rv_pkg::IDLE;
			valid <= 1'b0;
		end else begin
			case (state)
				rv_pkg::IDLE: begin
					if (!hit) begin
						valid <= 1'b0;
						state <= rv_pkg::WAIT;
					end
				end
				rv_pkg::WAIT: begin
					if (i_im_ready) begin
						valid <= 1'b1;
						state <= rv_pkg::DONE;
					end
				end
				default: state <= rv_pkg::IDLE;
			endcase
		end
	end

	// Tag holds the requested address while waiting
	always_ff @(posedge i_clk) begin
		if ((state == rv_pkg::IDLE) && !hit) begin
			tag <= i_pc;
		end
		if ((state == rv_pkg::WAIT) && i_im_ready) begin
			instr_q <= i_im_data;
		end
	end

	assign o_stall       = !hit;
	assign o_instr       = instr_q;
	assign o_im_valid    = state == rv_pkg::WAIT;
	assign o_im_req.addr = tag;

endmodule

// ==== verilog/rv_core_top.sv ====
/*
	RV32I core top
	Fetch unit and datapath wired to the instruction and data ports
*/

`timescale 1ns/1ps

module rv_core_top (
	input  logic            i_clk,
	input  logic            i_rst,
	output logic            o_im_valid,
	output rv_pkg::im_req_t o_im_req,
	input  logic            i_im_ready,
	input  rv_pkg::word_t   i_im_data,
	output logic            o_dm_valid,
	output rv_pkg::dm_req_t o_dm_req,
	input  logic            i_dm_ready,
	input  rv_pkg::word_t   i_dm_rdata
);

	rv_pkg::addr_t pc;
	rv_pkg::word_t instr;
	logic          fetch_stall;

	rv_fetch u_fetch (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_pc       (pc),
		.o_instr    (instr),
		.o_stall    (fetch_stall),
		.o_im_valid (o_im_valid),
		.o_im_req   (o_im_req),
		.i_im_ready (i_im_ready),
		.i_im_data  (i_im_data)
	);

	rv_datapath u_datapath (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.o_pc          (pc),
		.i_instr       (instr),
		.i_fetch_stall (fetch_stall),
		.o_dm_valid    (o_dm_valid),
		.o_dm_req      (o_dm_req),
		.i_dm_ready    (i_dm_ready),
		.i_dm_rdata    (i_dm_rdata)
	);

endmodule

// ==== testbench/rv_core_chk.sv ====
/*
	Core protocol checker
	Request stability under back-pressure and reset behavior of both ports
*/

`timescale 1ns/1ps

module rv_core_chk (
	input logic            i_clk,
	input logic            i_rst,
	input logic            i_im_valid,
	input rv_pkg::im_req_t i_im_req,
	input logic            i_im_ready,
	input logic            i_dm_valid,
	input rv_pkg::dm_req_t i_dm_req,
	input logic            i_dm_ready
);

	int fail_count = 0;

	// Held until ready
	im_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_im_valid && !i_im_ready |=> i_im_valid && $stable(i_im_req))
		else begin
			fail_count++;
			$error("instruction request dropped or changed before ready");
		end

	dm_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_dm_valid && !i_dm_ready |=> i_dm_valid && $stable(i_dm_req))
		else begin
			fail_count++;
			$error("data request dropped or changed before ready");
		end

	dm_quiet_in_reset: assert property (@(posedge i_clk) !i_rst |=> !i_dm_valid)
		else begin
			fail_count++;
			$error("data request raised during reset");
		end

	first_fetch: assert property (@(posedge i_clk)
		$rose(i_rst) |=> i_im_valid && (i_im_req.addr == rv_pkg::PC_RESET))
		else begin
			fail_count++;
			$error("first fetch after reset is not at the reset address");
		end

endmodule

// ==== testbench/rv_ref_model.svh ====
/*
	Reference model of the RV32I subset
	Runs the program held in imem and queues the expected fetch
	addresses and store requests
*/

`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

function automatic rv_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
	input rv_pkg::word_t a, input rv_pkg::word_t b);
	case (f3)
		3'b000:  return alt ? a - b : a + b;
		3'b001:  return a << b[4:0];
		3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'b011:  return (a < b) ? 32'd1 : 32'd0;
		3'b100:  return a ^ b;
		3'b101: begin
			if (alt) begin
				return $signed(a) >>> b[4:0];
			end
			return a >> b[4:0];
		end
		3'b110:  return a | b;
		default: return a & b;
	endcase
endfunction

function automatic logic branch_model(input logic [2:0] f3, input rv_pkg::word_t a,
	input rv_pkg::word_t b);
	case (f3)
		rv_pkg::F3_BEQ:  return a == b;
		rv_pkg::F3_BNE:  return a != b;
		rv_pkg::F3_BLT:  return $signed(a) < $signed(b);
		rv_pkg::F3_BGE:  return $signed(a) >= $signed(b);
		rv_pkg::F3_BLTU: return a < b;
		rv_pkg::F3_BGEU: return a >= b;
		default:         return 1'b0;
	endcase
endfunction

task automatic run_model();
	rv_pkg::word_t   x [32];
	rv_pkg::addr_t   pc;
	rv_pkg::addr_t   next_pc;
	rv_pkg::addr_t   ea;
	rv_pkg::word_t   ins;
	rv_pkg::word_t   a;
	rv_pkg::word_t   b;
	rv_pkg::word_t   res;
	rv_pkg::word_t   word;
	rv_pkg::word_t   imm_i;
	rv_pkg::word_t   imm_s;
	rv_pkg::word_t   imm_b;
	rv_pkg::word_t   imm_u;
	rv_pkg::word_t   imm_j;
	rv_pkg::dm_req_t req;
	logic [6:0]      opc;
	logic [2:0]      f3;
	logic [4:0]      rd;
	logic            wr;
	logic            stop;
	int              steps;
	int              i;
	for (i = 0; i < 32; i++) begin
		x[i] = '0;
	end
	pc = rv_pkg::PC_RESET;
	stop = 1'b0;
	for (steps = 0; (steps < 5000) && !stop; steps++) begin
		exp_fetch.push_back(pc);
		ins   = imem[pc[9:2]];
		opc   = ins[6:0];
		f3    = ins[14:12];
		rd    = ins[11:7];
		a     = x[ins[19:15]];
		b     = x[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_u = {ins[31:12], 12'd0};
		imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		next_pc = pc + 32'd4;
		res = '0;
		wr  = 1'b1;
		case (opc)
			rv_pkg::OPC_OP:     res = alu_model(f3, ins[30], a, b);
			rv_pkg::OPC_OP_IMM: res = alu_model(f3, ins[30] && (f3 == 3'b101), a, imm_i);
			rv_pkg::OPC_LUI:    res = imm_u;
			rv_pkg::OPC_AUIPC:  res = pc + imm_u;
			rv_pkg::OPC_LOAD: begin
				ea = a + imm_i;
				word = model_mem[ea[9:2]] >> (8 * ea[1:0]);
				case (f3)
					rv_pkg::F3_B:  res = {{24{word[7]}}, word[7:0]};
					rv_pkg::F3_H:  res = {{16{word[15]}}, word[15:0]};
					rv_pkg::F3_BU: res = {24'd0, word[7:0]};
					rv_pkg::F3_HU: res = {16'd0, word[15:0]};
					default:       res = word;
				endcase
			end
			rv_pkg::OPC_STORE: begin
				wr = 1'b0;
				ea = a + imm_s;
				req.addr  = {ea[31:2], 2'b00};
				req.write = 1'b1;
				case (f3)
					rv_pkg::F3_B: begin
						req.strb  = 4'b0001 << ea[1:0];
						req.wdata = {4{b[7:0]}};
					end
					rv_pkg::F3_H: begin
						req.strb  = 4'b0011 << ea[1:0];
						req.wdata = {2{b[15:0]}};
					end
					default: begin
						req.strb  = 4'b1111;
						req.wdata = b;
					end
				endcase
				for (i = 0; i < 4; i++) begin
					if (req.strb[i]) begin
						model_mem[ea[9:2]][8*i +: 8] = req.wdata[8*i +: 8];
					end
				end
				exp_store.push_back(req);
			end
			rv_pkg::OPC_BRANCH: begin
				wr = 1'b0;
				if (branch_model(f3, a, b)) begin
					next_pc = pc + imm_b;
				end
			end
			rv_pkg::OPC_JAL: begin
				res = pc + 32'd4;
				next_pc = pc + imm_j;
				// Self-loop ends the program
				stop = (imm_j == '0);
			end
			rv_pkg::OPC_JALR: begin
				res = pc + 32'd4;
				next_pc = (a + imm_i) & ~32'd1;
			end
			default: wr = 1'b0;
		endcase
		if (wr && (rd != 5'd0)) begin
			x[rd] = res;
		end
		pc = next_pc;
	end
endtask

`endif

// ==== testbench/tb_core.sv ====
/*
	Testbench for the RV32I core
	Random program, instruction and data memories with random latency,
	fetches and stores checked against the instruction-set model
*/

`timescale 1ns/1ps

module tb_core;

	localparam int PROG_LEN   = 200;
	localparam int IDLE_LIMIT = 100;
	localparam int MAX_CYCLES = 20000;
	localparam rv_pkg::addr_t DATA_BASE = 32'h0000_1000;

	logic            clk;
	logic            rst;
	logic            im_valid;
	rv_pkg::im_req_t im_req;
	logic            im_ready;
	rv_pkg::word_t   im_data;
	logic            dm_valid;
	rv_pkg::dm_req_t dm_req;
	logic            dm_ready;
	rv_pkg::word_t   dm_rdata;

	rv_pkg::word_t   imem [256];
	rv_pkg::word_t   dmem [256];
	rv_pkg::word_t   model_mem [256];
	rv_pkg::addr_t   exp_fetch [$];
	rv_pkg::dm_req_t exp_store [$];
	int              prog_words;
	int              fetch_checks;
	int              store_checks;
	int              fetch_errors;
	int              store_errors;
	int              timeouts;

	`include "rv_ref_model.svh"

	rv_core_top DUT (
		.i_clk      (clk),
		.i_rst      (rst),
		.o_im_valid (im_valid),
		.o_im_req   (im_req),
		.i_im_ready (im_ready),
		.i_im_data  (im_data),
		.o_dm_valid (dm_valid),
		.o_dm_req   (dm_req),
		.i_dm_ready (dm_ready),
		.i_dm_rdata (dm_rdata)
	);

	bind rv_core_top rv_core_chk u_core_chk (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_im_valid (o_im_valid),
		.i_im_req   (o_im_req),
		.i_im_ready (i_im_ready),
		.i_dm_valid (o_dm_valid),
		.i_dm_req   (o_dm_req),
		.i_dm_ready (i_dm_ready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic rv_pkg::word_t fill_word(input rv_pkg::addr_t addr);
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]};
	endfunction

	function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
	endfunction

	function automatic rv_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic rv_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OPC_STORE};
	endfunction

	function automatic rv_pkg::word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
	endfunction

	function automatic rv_pkg::word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic rv_pkg::word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
	endfunction

	// Random programs only touch x0 to x15
	function automatic logic [4:0] rand_reg();
		return 5'($urandom % 16);
	endfunction

	// Offset from x20, aligned to the access size
	function automatic logic [11:0] mem_off(input logic [2:0] f3);
		logic [11:0] off;
		off = 12'($urandom % 1024);
		case (f3[1:0])
			2'b01:   off[0] = 1'b0;
			2'b10:   off[1:0] = 2'b00;
			default: ;
		endcase
		return off;
	endfunction

	function automatic logic [2:0] pick_load();
		case ($urandom % 5)
			0:       return rv_pkg::F3_B;
			1:       return rv_pkg::F3_H;
			2:       return rv_pkg::F3_W;
			3:       return rv_pkg::F3_BU;
			default: return rv_pkg::F3_HU;
		endcase
	endfunction

	function automatic logic [2:0] pick_branch();
		case ($urandom % 6)
			0:       return rv_pkg::F3_BEQ;
			1:       return rv_pkg::F3_BNE;
			2:       return rv_pkg::F3_BLT;
			3:       return rv_pkg::F3_BGE;
			4:       return rv_pkg::F3_BLTU;
			default: return rv_pkg::F3_BGEU;
		endcase
	endfunction

	task automatic emit(input rv_pkg::word_t w);
		imem[prog_words] = w;
		prog_words++;
	endtask

	task automatic emit_alu(output logic [4:0] rd);
		rv_pkg::word_t rnd;
		logic [2:0]    f3;
		logic          alt;
		rnd = $urandom;
		rd  = rand_reg();
		f3  = rnd[14:12];
		alt = rnd[30] && ((f3 == 3'b000) || (f3 == 3'b101));
		case ($urandom % 4)
			0: emit(enc_r({1'b0, alt, 5'b0}, rand_reg(), rand_reg(), f3, rd));
			1: begin
				if ((f3 == 3'b001) || (f3 == 3'b101)) begin
					emit(enc_i({1'b0, alt, 5'b0, rnd[24:20]}, rand_reg(), f3, rd,
						rv_pkg::OPC_OP_IMM));
				end else begin
					emit(enc_i(rnd[31:20], rand_reg(), f3, rd, rv_pkg::OPC_OP_IMM));
				end
			end
			2: emit(enc_u(rnd[31:12], rd, rv_pkg::OPC_LUI));
			default: emit(enc_u(rnd[31:12], rd, rv_pkg::OPC_AUIPC));
		endcase
	endtask

	// Skipped by a taken branch or a jump
	task automatic fillers(input int k);
		logic [4:0] rd;
		int         i;
		for (i = 0; i < k; i++) begin
			emit_alu(rd);
		end
	endtask

	task automatic build_program();
		rv_pkg::word_t rnd;
		logic [4:0]    rd;
		logic [4:0]    rs1;
		logic [4:0]    rs2;
		logic [2:0]    f3;
		int            k;
		int            r;
		for (r = 0; r < 256; r++) begin
			imem[r] = enc_j(21'd0, 5'd0);
		end
		prog_words = 0;
		// x20 is the data base, x21 the JALR base
		emit(enc_u(20'h00001, 5'd20, rv_pkg::OPC_LUI));
		for (r = 1; r < 16; r++) begin
			rnd = $urandom;
			emit(enc_u(rnd[31:12], r[4:0], rv_pkg::OPC_LUI));
			emit(enc_i(rnd[11:0], r[4:0], 3'b000, r[4:0], rv_pkg::OPC_OP_IMM));
		end
		while (prog_words < PROG_LEN) begin
			k = 1 + ($urandom % 3);
			case ($urandom % 6)
				0, 1: begin
					emit_alu(rd);
					emit(enc_s(mem_off(rv_pkg::F3_W), rd, 5'd20, rv_pkg::F3_W));
				end
				2: begin
					f3 = pick_load();
					rd = rand_reg();
					emit(enc_i(mem_off(f3), 5'd20, f3, rd, rv_pkg::OPC_LOAD));
					emit(enc_s(mem_off(rv_pkg::F3_W), rd, 5'd20, rv_pkg::F3_W));
				end
				3: begin
					f3 = 3'($urandom % 3);
					emit(enc_s(mem_off(f3), rand_reg(), 5'd20, f3));
				end
				4: begin
					rs1 = rand_reg();
					rs2 = (($urandom % 4) == 0) ? rs1 : rand_reg();
					emit(enc_b(13'(4 * (k + 1)), rs2, rs1, pick_branch()));
					fillers(k);
				end
				default: begin
					rd = rand_reg();
					if (($urandom % 2) == 0) begin
						emit(enc_j(21'(4 * (k + 1)), rd));
					end else begin
						emit(enc_u(20'd0, 5'd21, rv_pkg::OPC_AUIPC));
						// Odd offset exercises the cleared bit 0
						emit(enc_i(12'(4 * (k + 2) + ($urandom % 2)), 5'd21, 3'b000, rd,
							rv_pkg::OPC_JALR));
					end
					fillers(k);
				end
			endcase
		end
		emit(enc_j(21'd0, 5'd0));
	endtask

	task automatic compare_fetch(input rv_pkg::addr_t act);
		rv_pkg::addr_t exp;
		fetch_checks++;
		if (exp_fetch.size() == 0) begin
			$display("ERROR %0t: fetch of %h after the expected sequence ended", $time, act);
			fetch_errors++;
		end else begin
			exp = exp_fetch.pop_front();
			if (act !== exp) begin
				$display("ERROR %0t: fetch expected %h got %h", $time, exp, act);
				fetch_errors++;
			end
		end
	endtask

	task automatic compare_store(input rv_pkg::dm_req_t act);
		rv_pkg::dm_req_t exp;
		rv_pkg::word_t   mask;
		int              i;
		store_checks++;
		if (exp_store.size() == 0) begin
			$display("ERROR %0t: store to %h after the expected stores ended", $time, act.addr);
			store_errors++;
		end else begin
			exp = exp_store.pop_front();
			for (i = 0; i < 4; i++) begin
				mask[8*i +: 8] = {8{exp.strb[i]}};
			end
			if ((act.addr !== exp.addr) || (act.strb !== exp.strb) ||
				(act.write !== exp.write) ||
				((act.wdata & mask) !== (exp.wdata & mask))) begin
				$display("ERROR %0t: store addr/data/strb expected %h/%h/%b got %h/%h/%b",
					$time, exp.addr, exp.wdata & mask, exp.strb,
					act.addr, act.wdata & mask, act.strb);
				store_errors++;
			end
		end
	endtask

	// Instruction memory, 0 to 3 cycles before ready
	initial begin : imem_model
		int wait_cnt;
		wait_cnt = -1;
		forever begin
			@(posedge clk);
			#1;
			if (im_ready) begin
				im_ready = 1'b0;
			end else if (im_valid) begin
				if (wait_cnt < 0) begin
					wait_cnt = $urandom % 4;
				end
				if (wait_cnt == 0) begin
					compare_fetch(im_req.addr);
					im_data  = imem[im_req.addr[9:2]];
					im_ready = 1'b1;
				end
				wait_cnt--;
			end
		end
	end

	initial begin : dmem_model
		rv_pkg::dm_req_t req;
		int              wait_cnt;
		int              i;
		wait_cnt = -1;
		forever begin
			@(posedge clk);
			#1;
			if (dm_ready) begin
				dm_ready = 1'b0;
			end else if (dm_valid) begin
				if (wait_cnt < 0) begin
					wait_cnt = $urandom % 4;
				end
				if (wait_cnt == 0) begin
					req = dm_req;
					if (req.write) begin
						compare_store(req);
						for (i = 0; i < 4; i++) begin
							if (req.strb[i]) begin
								dmem[req.addr[9:2]][8*i +: 8] = req.wdata[8*i +: 8];
							end
						end
					end
					dm_rdata = dmem[req.addr[9:2]];
					dm_ready = 1'b1;
				end
				wait_cnt--;
			end
		end
	end

	initial begin
		int   idle;
		int   cycles;
		int   last_fetches;
		int   i;
		logic finished;
		rst      = 1'b0;
		im_ready = 1'b0;
		im_data  = '0;
		dm_ready = 1'b0;
		dm_rdata = '0;
		fetch_checks = 0;
		store_checks = 0;
		fetch_errors = 0;
		store_errors = 0;
		timeouts     = 0;
		void'($urandom(32'h3afd));
		build_program();
		for (i = 0; i < 256; i++) begin
			dmem[i]      = fill_word(DATA_BASE + 4 * i);
			model_mem[i] = dmem[i];
		end
		run_model();
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b1;

		// Runs until every predicted fetch and store has been seen
		idle = 0;
		cycles = 0;
		last_fetches = 0;
		finished = 1'b0;
		while (!finished && (idle < IDLE_LIMIT) && (cycles < MAX_CYCLES)) begin
			@(posedge clk);
			cycles++;
			if (fetch_checks != last_fetches) begin
				idle = 0;
				last_fetches = fetch_checks;
			end else begin
				idle++;
			end
			finished = (exp_fetch.size() == 0) && (exp_store.size() == 0);
		end
		if (!finished) begin
			if (idle >= IDLE_LIMIT) begin
				$display("Timeout: core stopped requesting instructions for %0d cycles",
					IDLE_LIMIT);
			end else begin
				$display("Timeout: program did not finish within %0d cycles", MAX_CYCLES);
			end
			$display("%0d expected fetches and %0d expected stores never seen",
				exp_fetch.size(), exp_store.size());
			timeouts++;
		end else begin
			// The self-loop must not fetch or store again
			repeat (20) @(posedge clk);
		end
		$display("Errors: fetch %0d store %0d timeout %0d assert %0d (%0d fetches, %0d stores)",
			fetch_errors, store_errors, timeouts, DUT.u_core_chk.fail_count,
			fetch_checks, store_checks);
		if ((fetch_errors + store_errors + timeouts + DUT.u_core_chk.fail_count) == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+testbench
common/rv_pkg.sv
core/rv_main_control.sv
core/rv_imm_gen.sv
core/rv_alu.sv
core/rv_reg_file.sv
core/rv_data_port.sv
core/rv_datapath.sv
verilog/rv_fetch.sv
verilog/rv_core_top.sv
testbench/rv_core_chk.sv
testbench/tb_core.sv
